/* src.f */
+incdir+hw
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/functDecode.sv
hw/opcodeDecode.sv
hw/decodeIssue.sv
hw/mipsDecoder.sv
dv/tbMipsDecoder.sv

/* Makefile */
SIM := verilator
SIMFLAGS := --binary --timing --assert
TOP := tbMipsDecoder
FILELIST := src.f

BUILD := obj_dir
BIN := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/decoder_defines.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD)

/* dv/tbMipsDecoder.sv */
/*
	Self-checking testbench for the MIPS decode stage with a random instruction
	stream, a credit consumer, a reference model and assertion checks
*/
`timescale 1ns/1ps
`default_nettype none
`include "decoder_defines.svh"

module tbMipsDecoder;

	import isaPkg::*;
	import ctrlPkg::*;

	localparam int numInstr = 400; // Accepted instructions in the random phase
	localparam int watchdogCycles = numInstr * 8 + 200;
	localparam logic [5:0] functTab [13] = '{SLL, SRL, JR, ADD, ADDU, SUB, SUBU,
		AND, OR, XOR, NOR, SLT, SLTU};
	localparam logic [5:0] opTab [15] = '{J, JAL, BEQ, BNE, ADDI, ADDIU, SLTI,
		SLTIU, ANDI, ORI, XORI, LUI, LW, SW, HALT};

	logic clk;
	logic arstN;
	logic instrValid;
	instr_t instr;
	logic instrReady;
	logic ctrlValid;
	decoded_t ctrl;
	logic creditReturn;

	decoded_t expQ[$]; // Words owed by the DUT in order
	decoded_t expCur; // Word expected on the current ctrlValid
	logic [31:0] rngState;
	logic stall; // Consumer holds all slots
	logic lastAccept;
	logic lastReturn;
	int tbCredits; // Model of the credit counter
	int held; // Slots the consumer has not freed yet
	int accepted;
	int cycle;
	int errCount; // Failures seen by the stimulus process
	int assertErrors; // Failures seen by the concurrent checks

	mipsDecoder u_dut (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.instrReady(instrReady),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl),
		.creditReturn(creditReturn)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	// Mostly legal encodings, some unknown functs and fully random words
	function automatic instr_t pickInstr();
		logic [31:0] r;
		logic [31:0] w;
		int idx;
		r = nextRand();
		w = nextRand(); // Register fields and immediate
		idx = int'(r % 32);
		if (idx < 13)
			w = {6'h00, w[25:6], functTab[idx]};
		else if (idx < 28)
			w = {opTab[idx-13], w[25:0]};
		else if (idx < 30)
			w = {6'h00, w[25:0]}; // R-type with funct often unknown
		return w;
	endfunction

	// Expected control word from the decode rules
	function automatic decoded_t model(input instr_t w);
		decoded_t d;
		regDst_t dst;
		extKind_t ext;
		logic [31:0] raw;
		raw = w;
		d = '0;
		d.aluOp = ALU_NONE;
		dst = DST_RT;
		ext = EXT_NONE;
		d.rs = w.rs;
		d.rt = w.rt;
		if (w.opcode == RTYPE)
		begin
			dst = DST_RD;
			case (w.funct)
				SLL: d.aluOp = ALU_SLL;
				SRL: d.aluOp = ALU_SRL;
				JR: d.jmpSel = PC_REG; // Jump to R[rs]
				ADD, ADDU: d.aluOp = ALU_ADD;
				SUB, SUBU: d.aluOp = ALU_SUB;
				AND: d.aluOp = ALU_AND;
				OR: d.aluOp = ALU_OR;
				XOR: d.aluOp = ALU_XOR;
				NOR: d.aluOp = ALU_NOR;
				SLT: d.aluOp = ALU_SLT;
				SLTU: d.aluOp = ALU_SLTU;
				default: d.illegal = 1'b1;
			endcase
			d.regWrite = !(d.illegal || w.funct == JR);
			if (d.illegal)
				dst = DST_RT; // Illegal word keeps the default destination
			if (w.funct == SLL || w.funct == SRL)
			begin
				d.aluSrc = SRC_SHAMT;
				d.shamt = w.shamt;
			end
		end
		else
		begin
			case (w.opcode)
				ADDI, ADDIU, LW, SW: d.aluOp = ALU_ADD;
				SLTI: d.aluOp = ALU_SLT;
				SLTIU: d.aluOp = ALU_SLTU;
				ANDI: d.aluOp = ALU_AND;
				ORI: d.aluOp = ALU_OR;
				XORI: d.aluOp = ALU_XOR;
				BEQ, BNE: d.aluOp = ALU_SUB; // Compare by subtraction
				default: d.aluOp = ALU_NONE;
			endcase
			case (w.opcode)
				ADDI, ADDIU, SLTI, SLTIU, LW, SW, BEQ, BNE: ext = EXT_SIGN;
				ANDI, ORI, XORI: ext = EXT_ZERO;
				LUI: ext = EXT_UPPER;
				J, JAL: ext = EXT_TARGET;
				HALT: d.halt = 1'b1;
				default: d.illegal = 1'b1;
			endcase
			if (w.opcode inside {ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI, LW, SW})
				d.aluSrc = SRC_IMM;
			d.regWrite = w.opcode inside {ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI,
				LUI, LW, JAL};
			d.memRead = (w.opcode == LW);
			d.memWrite = (w.opcode == SW);
			if (w.opcode == LW)
				d.memToReg = WB_MEM;
			else if (w.opcode == LUI)
				d.memToReg = WB_UPPER;
			else if (w.opcode == JAL)
				d.memToReg = WB_LINK;
			if (w.opcode == J || w.opcode == JAL)
				d.jmpSel = PC_TARGET;
			if (w.opcode == BEQ)
				d.branchCond = BR_EQ;
			else if (w.opcode == BNE)
				d.branchCond = BR_NE;
			if (w.opcode == JAL)
				dst = DST_LINK;
		end
		case (ext)
			EXT_SIGN: d.immediate = {{16{raw[15]}}, raw[15:0]};
			EXT_ZERO: d.immediate = {16'h0000, raw[15:0]};
			EXT_UPPER: d.immediate = {raw[15:0], 16'h0000};
			EXT_TARGET: d.immediate = {6'h00, raw[25:0]};
			default: d.immediate = '0;
		endcase
		d.wrReg = (dst == DST_LINK) ? `LINK_REG : (dst == DST_RD) ? w.rd : w.rt;
		return d;
	endfunction

	task automatic reportField(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			$display("MISMATCH %s got %h exp %h", name, got, exp);
	endtask

	task automatic reportWord(input decoded_t got, input decoded_t exp);
		reportField("aluOp", 32'(got.aluOp), 32'(exp.aluOp));
		reportField("aluSrc", 32'(got.aluSrc), 32'(exp.aluSrc));
		reportField("memToReg", 32'(got.memToReg), 32'(exp.memToReg));
		reportField("jmpSel", 32'(got.jmpSel), 32'(exp.jmpSel));
		reportField("branchCond", 32'(got.branchCond), 32'(exp.branchCond));
		reportField("regWrite", 32'(got.regWrite), 32'(exp.regWrite));
		reportField("memRead", 32'(got.memRead), 32'(exp.memRead));
		reportField("memWrite", 32'(got.memWrite), 32'(exp.memWrite));
		reportField("halt", 32'(got.halt), 32'(exp.halt));
		reportField("illegal", 32'(got.illegal), 32'(exp.illegal));
		reportField("rs", 32'(got.rs), 32'(exp.rs));
		reportField("rt", 32'(got.rt), 32'(exp.rt));
		reportField("wrReg", 32'(got.wrReg), 32'(exp.wrReg));
		reportField("shamt", 32'(got.shamt), 32'(exp.shamt));
		reportField("immediate", got.immediate, exp.immediate);
	endtask

	// One clock of stimulus entered just after a falling edge
	task automatic step(input logic wantValid, input logic spurious);
		logic retCounts;
		retCounts = lastReturn && (tbCredits != `CREDIT_DEPTH); // Full counter ignores it
		if (lastAccept && !retCounts)
			tbCredits--;
		else if (!lastAccept && retCounts)
			tbCredits++;
		if (ctrlValid)
		begin
			if (expQ.size() == 0)
			begin
				errCount++;
				$display("Control word issued with no accepted instruction behind it");
			end
			else
				expCur = expQ.pop_front(); // Checked at the next rising edge
			held++; // Consumer takes every word
		end
		creditReturn = spurious || (held > 0 && !stall && nextRand() % 3 == 0);
		if (creditReturn && held > 0)
			held--;
		instrValid = wantValid;
		instr = pickInstr();
		lastAccept = wantValid && instrReady; // Ready only moves on rising edges
		lastReturn = creditReturn;
		if (lastAccept)
		begin
			expQ.push_back(model(instr));
			accepted++;
		end
		cycle++;
		@(negedge clk);
	endtask

	assert property (@(posedge clk) disable iff (!arstN) ctrlValid |-> (ctrl == expCur))
	else
	begin
		assertErrors++;
		reportWord($sampled(ctrl), expCur);
	end

	// Word follows its acceptance by exactly one cycle
	assert property (@(posedge clk) disable iff (!arstN)
		ctrlValid == $past(instrValid && tbCredits != 0))
	else
	begin
		assertErrors++;
		$display("MISMATCH ctrlValid got %h exp %h", $sampled(ctrlValid),
			!$sampled(ctrlValid));
	end

	assert property (@(posedge clk) disable iff (!arstN) instrReady == (tbCredits != 0))
	else
	begin
		assertErrors++;
		$display("MISMATCH instrReady got %h exp %h", $sampled(instrReady), tbCredits != 0);
	end

	initial
	begin
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		creditReturn = 1'b0;
		rngState = 32'haac0c94e;
		stall = 1'b1;
		lastAccept = 1'b0;
		lastReturn = 1'b0;
		tbCredits = `CREDIT_DEPTH;
		held = 0;
		accepted = 0;
		cycle = 0;
		errCount = 0;
		assertErrors = 0;
		expCur = '0;
		repeat (8) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		assert (ctrlValid === 1'b0)
		else
		begin
			errCount++;
			$display("MISMATCH ctrlValid got %h exp %h", ctrlValid, 1'b0);
		end
		assert (instrReady === 1'b1)
		else
		begin
			errCount++;
			$display("MISMATCH instrReady got %h exp %h", instrReady, 1'b1);
		end
		step(1'b0, 1'b1); // Return while full must not add a credit
		while (instrReady && accepted < 2 * `CREDIT_DEPTH)
			step(1'b1, 1'b0); // No returns yet
		assert (accepted == `CREDIT_DEPTH)
		else
		begin
			errCount++;
			$display("MISMATCH acceptedBeforeStall got %h exp %h", accepted, `CREDIT_DEPTH);
		end
		repeat (3) step(1'b1, 1'b0); // Held off so nothing is accepted
		stall = 1'b0;
		while (accepted < numInstr)
		begin
			stall = (cycle >= 300 && cycle < 380); // Long consumer stall
			step(nextRand() % 4 != 0, 1'b0);
		end
		repeat (4) step(1'b0, 1'b0); // Drain the last words
		if (expQ.size() != 0)
		begin
			errCount++;
			$display("%0d accepted instructions never produced a control word", expQ.size());
		end
		$display("Checked %0d instructions: %0d assertion errors, %0d sequence errors",
			accepted, assertErrors, errCount);
		if (errCount == 0 && assertErrors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout: instruction stream stalled after %0d of %0d, %0d errors so far",
			accepted, numInstr, errCount + assertErrors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/mipsDecoder.sv */
/*
	Decode stage top: funct and opcode decoders feeding the issue stage
*/
`timescale 1ns/1ps
`default_nettype none
`include "decoder_defines.svh"

module mipsDecoder (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input isaPkg::instr_t instr,
	output logic instrReady,
	output logic ctrlValid,
	output ctrlPkg::decoded_t ctrl,
	input logic creditReturn // One pulse per freed slot
);

	import ctrlPkg::*;

	ctrlFields_t rCtrl; // R-type result
	ctrlFields_t iCtrl; // I/J-type result
	logic isRType;

	functDecode uFunctDecode (
		.funct(instr.funct),
		.rCtrl(rCtrl)
	);

	opcodeDecode uOpcodeDecode (
		.opcode(instr.opcode),
		.iCtrl(iCtrl),
		.isRType(isRType)
	);

	decodeIssue uDecodeIssue (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.isRType(isRType),
		.rCtrl(rCtrl),
		.iCtrl(iCtrl),
		.creditReturn(creditReturn),
		.instrReady(instrReady),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl)
	);

endmodule

`default_nettype wire

/* hw/decodeIssue.sv */
/*
	Issue stage: merges decoder outputs, extracts fields, registers the
	control word and keeps the consumer credit count
*/
`timescale 1ns/1ps
`default_nettype none
`include "decoder_defines.svh"

module decodeIssue (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input isaPkg::instr_t instr,
	input logic isRType,
	input ctrlPkg::ctrlFields_t rCtrl,
	input ctrlPkg::ctrlFields_t iCtrl,
	input logic creditReturn,
	output logic instrReady,
	output logic ctrlValid,
	output ctrlPkg::decoded_t ctrl
);

	import isaPkg::*;
	import ctrlPkg::*;

	localparam logic [`CREDIT_CNT_WIDTH-1:0] creditMax = `CREDIT_CNT_WIDTH'(`CREDIT_DEPTH);

	ctrlFields_t sel; // Active decoder result
	regAddr_t wrReg;
	logic [`DATA_WIDTH-1:0] imm;
	logic [`SHAMT_WIDTH-1:0] shamtSel;
	logic [`CREDIT_CNT_WIDTH-1:0] credits; // Free consumer slots
	logic accept;
	logic creditIn; // Return that actually counts
	decoded_t nextWord;

	assign sel = isRType ? rCtrl : iCtrl;

	always_comb
	begin
		case (sel.regDst)
			DST_RD: wrReg = instr.rd;
			DST_LINK: wrReg = `LINK_REG; // $ra
			default: wrReg = instr.rt;
		endcase
	end

	// Immediate built from the low bits of the word
	always_comb
	begin
		case (sel.extKind)
			EXT_SIGN: imm = {{(`DATA_WIDTH-`IMM_WIDTH){instr[`IMM_WIDTH-1]}},
				instr[`IMM_WIDTH-1:0]};
			EXT_ZERO: imm = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, instr[`IMM_WIDTH-1:0]};
			EXT_UPPER: imm = {instr[`IMM_WIDTH-1:0], {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
			EXT_TARGET: imm = {{(`DATA_WIDTH-`TARGET_WIDTH){1'b0}},
				instr[`TARGET_WIDTH-1:0]}; // Word index, PC bits added later
			default: imm = '0;
		endcase
	end

	assign shamtSel = (sel.aluSrc == SRC_SHAMT) ? instr.shamt : '0;

	assign nextWord = '{
		aluOp: sel.aluOp, aluSrc: sel.aluSrc, memToReg: sel.memToReg,
		jmpSel: sel.jmpSel, branchCond: sel.branchCond,
		regWrite: sel.regWrite, memRead: sel.memRead, memWrite: sel.memWrite,
		halt: sel.halt, illegal: sel.illegal,
		rs: instr.rs, rt: instr.rt, wrReg: wrReg, shamt: shamtSel,
		immediate: imm
	};

	assign instrReady = (credits != '0); // Any slot left
	assign accept = instrValid && instrReady;
	assign creditIn = creditReturn && (credits != creditMax); // Drop spurious return

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			credits <= creditMax;
			ctrlValid <= 1'b0;
		end
		else
		begin
			ctrlValid <= accept; // One pulse per word
			case ({accept, creditIn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			ctrl <= nextWord; // Payload
	end

endmodule

`default_nettype wire

/* hw/opcodeDecode.sv */
/*
	Primary opcode decoder for I- and J-type words; also flags R-type
*/
`timescale 1ns/1ps
`default_nettype none

module opcodeDecode (
	input isaPkg::opcode_t opcode,
	output ctrlPkg::ctrlFields_t iCtrl,
	output logic isRType
);

	import isaPkg::*;
	import ctrlPkg::*;

	assign isRType = (opcode == RTYPE); // Only place this test is made

	always_comb
	begin
		iCtrl = ctrlNop;

		case (opcode)
			RTYPE:
			begin
				iCtrl = ctrlNop; // Funct decoder takes over
			end
			ADDI, ADDIU:
			begin
				iCtrl.aluOp = ALU_ADD;
				iCtrl.aluSrc = SRC_IMM;
				iCtrl.extKind = EXT_SIGN;
				iCtrl.regWrite = 1'b1; // R[rt]
			end
			SLTI, SLTIU:
			begin
				iCtrl.aluOp = (opcode == SLTI) ? ALU_SLT : ALU_SLTU;
				iCtrl.aluSrc = SRC_IMM;
				iCtrl.extKind = EXT_SIGN; // Sign extended even for SLTIU
				iCtrl.regWrite = 1'b1;
			end
			ANDI, ORI, XORI:
			begin
				case (opcode)
					ANDI: iCtrl.aluOp = ALU_AND;
					ORI: iCtrl.aluOp = ALU_OR;
					default: iCtrl.aluOp = ALU_XOR;
				endcase
				iCtrl.aluSrc = SRC_IMM;
				iCtrl.extKind = EXT_ZERO; // Logical ops zero extend
				iCtrl.regWrite = 1'b1;
			end
			LUI:
			begin
				iCtrl.aluSrc = SRC_IMM;
				iCtrl.extKind = EXT_UPPER; // {imm, 16'b0}
				iCtrl.memToReg = WB_UPPER; // Bypasses the ALU
				iCtrl.regWrite = 1'b1;
			end
			J, JAL:
			begin
				iCtrl.extKind = EXT_TARGET;
				iCtrl.jmpSel = PC_TARGET;
				if (opcode == JAL)
				begin
					iCtrl.regDst = DST_LINK; // R[31] <= return address
					iCtrl.memToReg = WB_LINK;
					iCtrl.regWrite = 1'b1;
				end
			end
			BEQ, BNE:
			begin
				iCtrl.aluOp = ALU_SUB; // rs - rt, zero flag decides
				iCtrl.extKind = EXT_SIGN; // Branch offset
				iCtrl.branchCond = (opcode == BEQ) ? BR_EQ : BR_NE;
			end
			LW:
			begin
				iCtrl.aluOp = ALU_ADD; // Base + offset
				iCtrl.aluSrc = SRC_IMM;
				iCtrl.extKind = EXT_SIGN;
				iCtrl.memRead = 1'b1;
				iCtrl.memToReg = WB_MEM;
				iCtrl.regWrite = 1'b1; // No cache, load always writes
			end
			SW:
			begin
				iCtrl.aluOp = ALU_ADD;
				iCtrl.aluSrc = SRC_IMM;
				iCtrl.extKind = EXT_SIGN;
				iCtrl.memWrite = 1'b1;
			end
			HALT:
			begin
				iCtrl.halt = 1'b1; // No register write
			end
			default:
			begin
				iCtrl = ctrlIllegal;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/functDecode.sv */
/*
	R-type decoder, funct code to control fields
*/
`timescale 1ns/1ps
`default_nettype none

module functDecode (
	input isaPkg::funct_t funct,
	output ctrlPkg::ctrlFields_t rCtrl
);

	import isaPkg::*;
	import ctrlPkg::*;

	always_comb
	begin
		rCtrl = ctrlNop;
		rCtrl.regWrite = 1'b1; // All R-type but JR write
		rCtrl.regDst = DST_RD; // R[rd]

		case (funct)
			SLL:
			begin
				rCtrl.aluOp = ALU_SLL;
				rCtrl.aluSrc = SRC_SHAMT; // Shift by shamt
			end
			SRL:
			begin
				rCtrl.aluOp = ALU_SRL;
				rCtrl.aluSrc = SRC_SHAMT;
			end
			JR:
			begin
				rCtrl.jmpSel = PC_REG; // PC <= R[rs]
				rCtrl.regWrite = 1'b0;
			end
			ADD, ADDU:
			begin
				rCtrl.aluOp = ALU_ADD; // Overflow not trapped
			end
			SUB, SUBU:
			begin
				rCtrl.aluOp = ALU_SUB;
			end
			AND:
			begin
				rCtrl.aluOp = ALU_AND;
			end
			OR:
			begin
				rCtrl.aluOp = ALU_OR;
			end
			XOR:
			begin
				rCtrl.aluOp = ALU_XOR;
			end
			NOR:
			begin
				rCtrl.aluOp = ALU_NOR;
			end
			SLT:
			begin
				rCtrl.aluOp = ALU_SLT; // Signed compare
			end
			SLTU:
			begin
				rCtrl.aluOp = ALU_SLTU;
			end
			default:
			begin
				rCtrl = ctrlIllegal; // Unknown funct, nothing written
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/ctrlPkg.sv */
/*
	Datapath control encodings, per-decoder control fields and the
	issued control word
*/
`default_nettype none
`include "decoder_defines.svh"

package ctrlPkg;

	typedef enum logic [3:0] {
		ALU_SLL = 4'h0, ALU_SRL = 4'h1, ALU_ADD = 4'h2, ALU_SUB = 4'h3,
		ALU_AND = 4'h4, ALU_OR = 4'h5, ALU_XOR = 4'h6, ALU_NOR = 4'h7,
		ALU_SLT = 4'h8, ALU_SLTU = 4'h9,
		ALU_NONE = 4'hf // ALU result unused
	} aluOp_t;

	typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_SHAMT} aluSrc_t; // ALU port B
	typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} regDst_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_UPPER, WB_LINK} memToReg_t; // Writeback mux
	typedef enum logic [1:0] {PC_NEXT, PC_TARGET, PC_REG} jmpSel_t; // PC source
	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branchCond_t;
	typedef enum logic [2:0] {
		EXT_NONE, EXT_SIGN, EXT_ZERO, EXT_UPPER, EXT_TARGET
	} extKind_t; // How the immediate is built

	// Output of either decoder, before field extraction
	typedef struct packed {
		aluOp_t aluOp;
		aluSrc_t aluSrc;
		regDst_t regDst;
		extKind_t extKind;
		memToReg_t memToReg;
		jmpSel_t jmpSel;
		branchCond_t branchCond;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic halt;
		logic illegal; // Unknown opcode or funct
	} ctrlFields_t;

	// Registered word handed to the consumer
	typedef struct packed {
		aluOp_t aluOp;
		aluSrc_t aluSrc;
		memToReg_t memToReg;
		jmpSel_t jmpSel;
		branchCond_t branchCond;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic halt;
		logic illegal;
		isaPkg::regAddr_t rs;
		isaPkg::regAddr_t rt;
		isaPkg::regAddr_t wrReg; // Resolved destination
		logic [`SHAMT_WIDTH-1:0] shamt;
		logic [`DATA_WIDTH-1:0] immediate; // Already extended
	} decoded_t;

	// Everything inactive
	localparam ctrlFields_t ctrlNop = '{
		aluOp: ALU_NONE, aluSrc: SRC_REG, regDst: DST_RT, extKind: EXT_NONE,
		memToReg: WB_ALU, jmpSel: PC_NEXT, branchCond: BR_NONE,
		regWrite: 1'b0, memRead: 1'b0, memWrite: 1'b0, halt: 1'b0, illegal: 1'b0
	};

	localparam ctrlFields_t ctrlIllegal = '{
		aluOp: ALU_NONE, aluSrc: SRC_REG, regDst: DST_RT, extKind: EXT_NONE,
		memToReg: WB_ALU, jmpSel: PC_NEXT, branchCond: BR_NONE,
		regWrite: 1'b0, memRead: 1'b0, memWrite: 1'b0, halt: 1'b0, illegal: 1'b1
	};

endpackage

`default_nettype wire

/* hw/isaPkg.sv */
/*
	MIPS instruction encoding: word layout, opcode and funct codes
*/
`default_nettype none
`include "decoder_defines.svh"

package isaPkg;

	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t; // Register index

	typedef enum logic [`OPCODE_WIDTH-1:0] {
		RTYPE = 6'h00, // Decoded by funct
		J = 6'h02,
		JAL = 6'h03,
		BEQ = 6'h04,
		BNE = 6'h05,
		ADDI = 6'h08,
		ADDIU = 6'h09,
		SLTI = 6'h0a,
		SLTIU = 6'h0b,
		ANDI = 6'h0c,
		ORI = 6'h0d,
		XORI = 6'h0e,
		LUI = 6'h0f,
		LW = 6'h23,
		SW = 6'h2b,
		HALT = 6'h3f
	} opcode_t;

	typedef enum logic [`FUNCT_WIDTH-1:0] {
		SLL = 6'h00, SRL = 6'h02, JR = 6'h08,
		ADD = 6'h20, ADDU = 6'h21, SUB = 6'h22, SUBU = 6'h23,
		AND = 6'h24, OR = 6'h25, XOR = 6'h26, NOR = 6'h27,
		SLT = 6'h2a, SLTU = 6'h2b
	} funct_t;

	// R layout; low 16 bits double as immediate, low 26 as target
	typedef struct packed {
		opcode_t opcode; // [31:26]
		regAddr_t rs; // [25:21]
		regAddr_t rt; // [20:16]
		regAddr_t rd; // [15:11]
		logic [`SHAMT_WIDTH-1:0] shamt; // [10:6]
		funct_t funct; // [5:0]
	} instr_t;

endpackage

`default_nettype wire

/* hw/decoder_defines.svh */
/*
	Decode stage widths, field sizes, link register and credit depth
*/
`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

`define DATA_WIDTH 32 // Full data word
`define REG_ADDR_WIDTH 5 // Register file index
`define OPCODE_WIDTH 6 // Primary opcode field
`define FUNCT_WIDTH 6 // R-type funct field
`define SHAMT_WIDTH 5 // Shift amount field
`define IMM_WIDTH 16 // Short immediate
`define TARGET_WIDTH 26 // Jump target

`define LINK_REG 5'd31 // $ra for JAL

// Consumer queue slots, one credit each
`define CREDIT_DEPTH 4
`define CREDIT_CNT_WIDTH 3 // Holds 0..CREDIT_DEPTH

`endif
